// File: src/bnn_cfg_pkg.sv
package bnn_cfg_pkg;

    // network dimensions
    localparam int feat_cnt   = 11;
    localparam int feat_bits  = 4;
    localparam int hidden_cnt = 40;
    localparam int class_cnt  = 6;

    localparam int sum_bits   = 8;  // 11 features * 15 = 165 max
    localparam int score_bits = 6;  // 0 .. 40
    localparam int class_bits = 3;

    // strobe in to result out, one register per layer
    localparam int pipe_latency = 3;

    typedef logic [feat_bits-1:0] feature_t;

    // feature 0 sits in the low bits
    typedef feature_t [feat_cnt-1:0] feature_vec_t;

    typedef logic [hidden_cnt-1:0] hidden_t;  // bit j is neuron j

    typedef logic [score_bits-1:0] score_t;
    typedef score_t [class_cnt-1:0] score_vec_t;

    typedef logic [class_bits-1:0] class_t;

    typedef struct packed {
        logic         valid;
        feature_vec_t feats;
    } feat_beat_t;

    typedef struct packed {
        logic    valid;
        hidden_t hidden;
    } hidden_beat_t;

    typedef struct packed {
        logic       valid;
        score_vec_t scores;
    } score_beat_t;

endpackage

// File: src/bnn_weights_pkg.sv
package bnn_weights_pkg;

    import bnn_cfg_pkg::*;

    // sign mask per hidden neuron, written as bit 10 down to bit 0
    // set bit: feature goes into the positive sum, clear: into the negative sum
    localparam logic [feat_cnt-1:0] hidden_mask [hidden_cnt] = '{
        11'b00110011000,  // 0
        11'b00111000000,
        11'b00011001000,
        11'b10100000101,
        11'b00100000111,
        11'b10101011011,  // 5
        11'b11100011001,
        11'b10100101110,
        11'b00110110000,
        11'b11111010111,
        11'b10000000110,  // 10
        11'b11011110000,
        11'b11111000101,
        11'b01110001101,
        11'b00101010011,
        11'b11101110111,  // 15
        11'b01010011110,
        11'b10101001110,
        11'b11111100000,
        11'b00010101100,
        11'b00010111011,  // 20
        11'b11101111111,
        11'b01101011101,
        11'b11100000001,
        11'b01100111000,
        11'b00000111100,  // 25
        11'b10111001100,
        11'b11010100001,
        11'b00110101000,
        11'b00111010011,
        11'b10000111110,  // 30
        11'b01001010100,
        11'b00001110001,
        11'b01100010011,
        11'b10110110001,
        11'b11111110110,  // 35
        11'b11011110110,
        11'b11001100100,
        11'b11110010010,
        11'b11101100111
    };

    // one 40-bit mask per class, hidden bit 39 on the left
    // set bit: hidden bit scores when 1, clear: scores when 0
    localparam logic [hidden_cnt-1:0] class_mask [class_cnt] = '{
        40'b00100010_11110000_00110111_00000100_00111001,  // class 0
        40'b11000110_10000001_10111000_00011101_00111101,
        40'b10101110_00110110_00100010_00010010_00000011,
        40'b10001010_11111101_11100101_01010010_11000101,
        40'b01101110_11001111_11100100_11110100_10001110,
        40'b10101111_01010101_11101111_01010100_01011110   // class 5
    };

endpackage

// File: src/bnn_hidden_layer.sv
module bnn_hidden_layer (
    input  logic                        clk,
    input  logic                        reset,
    input  bnn_cfg_pkg::feat_beat_t     in_beat,
    output bnn_cfg_pkg::hidden_beat_t   hidden_beat
);

    import bnn_cfg_pkg::*;
    import bnn_weights_pkg::*;

    hidden_t hidden_next;
    hidden_t hidden_q;
    logic    valid_q;

    // one comparator per neuron, the mask picks the side of each feature
    for (genvar j = 0; j < hidden_cnt; j++) begin : g_neuron
        logic [sum_bits-1:0] pos_sum;
        logic [sum_bits-1:0] neg_sum;

        always_comb begin
            pos_sum = '0;
            neg_sum = '0;
            for (int i = 0; i < feat_cnt; i++) begin
                if (hidden_mask[j][i])
                    pos_sum += in_beat.feats[i];
                else
                    neg_sum += in_beat.feats[i];
            end
        end

        assign hidden_next[j] = (pos_sum >= neg_sum);  // ties fire
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_beat.valid;
        end
    end

    // data only moves with a strobe
    always_ff @(posedge clk) begin
        if (in_beat.valid) begin
            hidden_q <= hidden_next;
        end
    end

    assign hidden_beat.valid  = valid_q;
    assign hidden_beat.hidden = hidden_q;

endmodule

// File: src/bnn_score_layer.sv
module bnn_score_layer (
    input  logic                        clk,
    input  logic                        reset,
    input  bnn_cfg_pkg::hidden_beat_t   hidden_beat,
    output bnn_cfg_pkg::score_beat_t    score_beat
);

    import bnn_cfg_pkg::*;
    import bnn_weights_pkg::*;

    score_vec_t scores_next;
    score_vec_t scores_q;
    logic       valid_q;

    // xnor popcount of the hidden bits against each class mask
    always_comb begin
        hidden_t match;

        for (int c = 0; c < class_cnt; c++) begin
            match = ~(hidden_beat.hidden ^ class_mask[c]);
            scores_next[c] = '0;
            for (int j = 0; j < hidden_cnt; j++) begin
                scores_next[c] += match[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= hidden_beat.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hidden_beat.valid) begin
            scores_q <= scores_next;
        end
    end

    assign score_beat.valid  = valid_q;
    assign score_beat.scores = scores_q;

endmodule

// File: src/class_argmax.sv
module class_argmax (
    input  logic                        clk,
    input  logic                        reset,
    input  bnn_cfg_pkg::score_beat_t    score_beat,
    output logic                        out_valid,
    output bnn_cfg_pkg::class_t         prediction
);

    import bnn_cfg_pkg::*;

    class_t best_idx;
    score_t best_score;

    // ascending scan, strict compare keeps the lowest index on a tie
    always_comb begin
        best_idx   = '0;
        best_score = score_beat.scores[0];
        for (int c = 1; c < class_cnt; c++) begin
            if (score_beat.scores[c] > best_score) begin
                best_score = score_beat.scores[c];
                best_idx   = class_t'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= score_beat.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (score_beat.valid) begin
            prediction <= best_idx;  // held until the next result
        end
    end

endmodule

// File: src/bnn_classifier.sv
module bnn_classifier (
    input  logic                        clk,
    input  logic                        reset,
    input  bnn_cfg_pkg::feat_beat_t     in_beat,
    output logic                        out_valid,
    output bnn_cfg_pkg::class_t         prediction
);

    import bnn_cfg_pkg::*;

    hidden_beat_t hidden_beat;  // stage 1 -> 2
    score_beat_t  score_beat;   // stage 2 -> 3

    // decode: hidden layer
    bnn_hidden_layer u_hidden (
        .clk         (clk),
        .reset       (reset),
        .in_beat     (in_beat),
        .hidden_beat (hidden_beat)
    );

    // execute: class scores
    bnn_score_layer u_score (
        .clk         (clk),
        .reset       (reset),
        .hidden_beat (hidden_beat),
        .score_beat  (score_beat)
    );

    // result: winning class
    class_argmax u_argmax (
        .clk        (clk),
        .reset      (reset),
        .score_beat (score_beat),
        .out_valid  (out_valid),
        .prediction (prediction)
    );

endmodule

// File: test/bnn_model.svh
`ifndef BNN_MODEL_SVH
`define BNN_MODEL_SVH

// a neuron fires when its positive sum reaches its negative sum
function automatic hidden_t hidden_bits(input feature_vec_t feats);
    hidden_t h;
    int pos;
    int neg;
    for (int j = 0; j < hidden_cnt; j++) begin
        pos = 0;
        neg = 0;
        for (int i = 0; i < feat_cnt; i++) begin
            if (hidden_mask[j][i])
                pos = pos + int'(feats[i]);
            else
                neg = neg + int'(feats[i]);
        end
        h[j] = (pos >= neg);
    end
    return h;
endfunction

// score = number of hidden bits that agree with the class mask
function automatic score_vec_t class_scores(input hidden_t h);
    score_vec_t s;
    int agree;
    for (int c = 0; c < class_cnt; c++) begin
        agree = 0;
        for (int j = 0; j < hidden_cnt; j++) begin
            if (h[j] == class_mask[c][j])
                agree++;
        end
        s[c] = score_t'(agree);
    end
    return s;
endfunction

function automatic int top_score(input score_vec_t s);
    int top;
    top = 0;
    for (int c = 0; c < class_cnt; c++) begin
        if (int'(s[c]) > top)
            top = int'(s[c]);
    end
    return top;
endfunction

// first class that reaches the top score
function automatic class_t best_class(input score_vec_t s);
    int top;
    top = top_score(s);
    for (int c = 0; c < class_cnt; c++) begin
        if (int'(s[c]) == top)
            return class_t'(c);
    end
    return '0;
endfunction

function automatic logic top_score_tied(input score_vec_t s);
    int top;
    int hits;
    top = top_score(s);
    hits = 0;
    for (int c = 0; c < class_cnt; c++) begin
        if (int'(s[c]) == top)
            hits++;
    end
    return (hits > 1);
endfunction

`endif

// File: test/tb_bnn_classifier.sv
module tb_bnn_classifier;

    timeunit 1ns;
    timeprecision 100ps;

    import bnn_cfg_pkg::*;
    import bnn_weights_pkg::*;

    `include "bnn_model.svh"

    localparam int clk_period   = 20;
    localparam int drive_dly    = 2;     // after the rising edge
    localparam int reset_cycles = 3;
    localparam int n_corner     = 2 + 2 * feat_cnt;
    localparam int n_b2b        = 300;
    localparam int n_gap        = 200;
    localparam int max_gap      = 3;
    localparam int n_flight     = 3;
    localparam int n_after      = 20;
    localparam int timeout_cycles = reset_cycles + n_corner + n_b2b + n_gap * (max_gap + 1)
                                  + n_flight + reset_cycles + n_after
                                  + 6 * (pipe_latency + 3) + 100;

    typedef struct packed {
        class_t cls;
        logic   tie;
        int     cycle;  // cyc value at the negedge that sees out_valid
        int     id;
    } expect_t;

    logic       clk;
    logic       reset;
    feat_beat_t in_beat;
    logic       out_valid;
    class_t     prediction;

    integer  seed;
    int      cyc;
    int      errors;
    int      vec_id;
    int      tie_cases;
    int      tie_hits;
    string   test_name;
    expect_t exp_q[$];

    bnn_classifier UUT (
        .clk        (clk),
        .reset      (reset),
        .in_beat    (in_beat),
        .out_valid  (out_valid),
        .prediction (prediction)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            $display("timeout: run still busy after %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // outputs settle after the edge, so look at them on the falling edge
    always @(negedge clk) begin
        expect_t e;
        if (reset === 1'b1 && out_valid !== 1'b0) begin
            errors++;
            $display("out_valid not low during reset at cycle %0d", cyc);
        end else if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected result at cycle %0d with no vector in flight", cyc);
            end else begin
                e = exp_q.pop_front();
                if (e.cycle != cyc) begin
                    errors++;
                    $display("vector %0d came out at cycle %0d, due at cycle %0d",
                             e.id, cyc, e.cycle);
                end
                if (prediction !== e.cls) begin
                    errors++;
                    $display("** Error %s vector %0d: expected class %0d, actual %0d",
                             test_name, e.id, e.cls, prediction);
                end else if (e.tie) begin
                    tie_hits++;
                end
            end
        end else if (out_valid !== 1'b0) begin
            errors++;
            $display("out_valid unknown at cycle %0d", cyc);
        end
        if (exp_q.size() > 0 && exp_q[0].cycle < cyc) begin
            e = exp_q.pop_front();
            errors++;
            $display("vector %0d never came out, was due at cycle %0d", e.id, e.cycle);
        end
    end

    function automatic feature_vec_t rand_vec();
        feature_vec_t v;
        for (int i = 0; i < feat_cnt; i++) begin
            v[i] = feature_t'($random(seed));
        end
        return v;
    endfunction

    task automatic send_vec(input feature_vec_t v);
        expect_t    e;
        score_vec_t s;
        s = class_scores(hidden_bits(v));
        e.cls = best_class(s);
        e.tie = top_score_tied(s);
        e.cycle = cyc + pipe_latency;  // seen on the negedge before edge cyc+1+pipe_latency
        e.id = vec_id;
        if (e.tie)
            tie_cases++;
        exp_q.push_back(e);
        vec_id++;
        in_beat.valid = 1'b1;
        in_beat.feats = v;
        @(posedge clk);
        #drive_dly;
        in_beat.valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            in_beat.valid = 1'b0;
            in_beat.feats = rand_vec();  // no strobe, data must not move
            @(posedge clk);
            #drive_dly;
        end
    endtask

    task automatic drain();
        while (exp_q.size() > 0)
            idle(1);
        idle(2);
    endtask

    initial begin
        feature_vec_t v;
        int gap;

        seed = 32'hd8ad973b;
        cyc = 0;
        errors = 0;
        vec_id = 0;
        tie_cases = 0;
        tie_hits = 0;
        test_name = "reset";
        reset = 1'b1;
        in_beat = '0;

        repeat (reset_cycles) @(posedge clk);
        #drive_dly;
        reset = 1'b0;
        idle(pipe_latency + 2);  // out_valid must stay low

        test_name = "corner";
        send_vec('0);  // every neuron fires on 0 >= 0
        v = '0;
        for (int i = 0; i < feat_cnt; i++)
            v[i] = 4'hf;
        send_vec(v);
        for (int i = 0; i < feat_cnt; i++) begin
            v = '0;
            v[i] = 4'h1;
            send_vec(v);
        end
        for (int i = 0; i < feat_cnt; i++) begin
            v = '0;
            v[i] = 4'hf;
            send_vec(v);
        end
        drain();

        test_name = "back_to_back";
        for (int k = 0; k < n_b2b; k++)
            send_vec(rand_vec());
        drain();

        test_name = "gapped";
        for (int k = 0; k < n_gap; k++) begin
            send_vec(rand_vec());
            gap = $random(seed) & max_gap;
            idle(gap);
        end
        drain();

        // reset lands on the edge that would show the first of three vectors
        test_name = "reset_in_flight";
        for (int k = 0; k < n_flight; k++) begin
            if (k == n_flight - 1)
                reset = 1'b1;
            send_vec(rand_vec());
        end
        in_beat.valid = 1'b0;
        exp_q.delete();
        repeat (reset_cycles - 1) @(posedge clk);
        #drive_dly;
        reset = 1'b0;
        idle(pipe_latency + 2);

        test_name = "after_reset";
        for (int k = 0; k < n_after; k++)
            send_vec(rand_vec());
        drain();

        if (tie_hits == 0) begin
            errors++;
            $display("coverage failure: no tied top score was checked");
        end
        $display("errors: %0d, vectors: %0d, tie cases: %0d sent, %0d checked",
                 errors, vec_id, tie_cases, tie_hits);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+test
src/bnn_cfg_pkg.sv
src/bnn_weights_pkg.sv
src/bnn_hidden_layer.sv
src/bnn_score_layer.sv
src/class_argmax.sv
src/bnn_classifier.sv
test/tb_bnn_classifier.sv
